// File: procPkg.sv
// shared types, opcodes and sizes for the pipelined core, imported by every RTL file
package procPkg;

   localparam int IMEM_DEPTH = 256;
   localparam int DMEM_DEPTH = 256;
   localparam int IMEM_AW = 8;
   localparam int DMEM_AW = 8;

   typedef logic [15:0] wordT;
   typedef logic [2:0] regIdxT;

   // register ALU ops share OP_ALU and pick the operation by the function field
   // 00 add, 01 sub, 10 xor, 11 andn
   typedef enum logic [4:0] {
      OP_HALT  = 5'b00000,
      OP_NOP   = 5'b00001,
      OP_J     = 5'b00100,
      OP_JAL   = 5'b00110,
      OP_ADDI  = 5'b01000,
      OP_SUBI  = 5'b01001,
      OP_XORI  = 5'b01010,
      OP_ANDNI = 5'b01011,
      OP_BEQZ  = 5'b01100,
      OP_BNEZ  = 5'b01101,
      OP_ST    = 5'b10000,
      OP_LD    = 5'b10001,
      OP_SLBI  = 5'b10010,
      OP_LBI   = 5'b11000,
      OP_ALU   = 5'b11011
   } opcodeT;

   typedef struct packed {
      opcodeT     op;
      regIdxT     rs;
      regIdxT     rt;
      regIdxT     rd;
      logic [1:0] func;
   } rFmtT;

   // lbi, slbi and the branches join rd and imm into one 8-bit immediate
   typedef struct packed {
      opcodeT     op;
      regIdxT     rs;
      regIdxT     rd;
      logic [4:0] imm;
   } iFmtT;

   typedef struct packed {
      opcodeT      op;
      logic [10:0] disp;
   } jFmtT;

   typedef union packed {
      rFmtT rFmt;
      iFmtT iFmt;
      jFmtT jFmt;
   } instrU;

   // sub is A minus B, andn is A and not B, slbi is (A << 8) | imm8
   typedef enum logic [2:0] {ALU_ADD, ALU_SUB, ALU_XOR, ALU_ANDN, ALU_PASSB, ALU_SLBI} aluOpT;

   typedef enum logic [2:0] {BR_NONE, BR_EQZ, BR_NEZ, BR_JUMP, BR_JAL} branchKindT;

   typedef struct packed {
      aluOpT      aluOp;
      logic       useImm;
      logic       memRead;
      logic       memWrite;
      logic       regWrite;
      branchKindT branchKind;
      logic       halt;
      logic       illegal;
   } ctrlT;

   typedef enum logic [1:0] {FWD_REG, FWD_MEM, FWD_WB} fwdSelT;

endpackage

// File: pipeIf.sv
// write-back bus and execute-to-fetch redirect bus shared by the pipeline stages
`timescale 1ns/100ps

interface wbBus import procPkg::*; ();

   logic   valid;
   logic   regWrite;
   regIdxT wrtReg;
   wordT   wbData;

   modport source (output valid, output regWrite, output wrtReg, output wbData);
   modport sink (input valid, input regWrite, input wrtReg, input wbData);

endinterface

interface redirectBus import procPkg::*; ();

   logic taken;
   wordT target;
   logic flush;
   logic stall;

   // a taken branch or jump squashes the two younger slots
   assign flush = taken;

   modport execute (output taken, output target);
   modport decode (output stall, input taken, input flush);
   modport fetch (input taken, input target, input flush, input stall);

endinterface

// File: fetch.sv
// fetch stage with the PC, the program memory and the fetch-to-decode register
`timescale 1ns/100ps

module fetch import procPkg::*; (
   input  logic               clk,
   input  logic               rst,
   input  logic               progWrEn,
   input  logic [IMEM_AW-1:0] progAddr,
   input  wordT               progData,
   redirectBus.fetch          redirect,
   input  logic               halted,
   output instrU              instrD,
   output wordT               pcIncD,
   output logic               validD
);

   wordT imem [IMEM_DEPTH];
   wordT pc;
   wordT pcInc;

   assign pcInc = pc + 16'd1;

   // program port is only open while the core is held in reset
   always_ff @(posedge clk) begin
      if (rst && progWrEn) begin
         imem[progAddr] <= progData;
      end
   end

   // PC and the valid bit of the fetch-to-decode register
   always_ff @(posedge clk) begin
      if (rst) begin
         pc <= '0;
         validD <= 1'b0;
      end else if (halted) begin
         // frozen after halt so decode only sees bubbles
         validD <= 1'b0;
      end else if (redirect.taken) begin
         pc <= redirect.target;
         validD <= 1'b0;
      end else if (!redirect.stall) begin
         pc <= pcInc;
         validD <= 1'b1;
      end
   end

   // instruction word and return address for decode
   always_ff @(posedge clk) begin
      if (!redirect.stall) begin
         instrD <= imem[pc[IMEM_AW-1:0]];
         pcIncD <= pcInc;
      end
   end

endmodule

// File: regFile.sv
// eight-entry register file written from the write-back bus, read by decode
`timescale 1ns/100ps

module regFile import procPkg::*; (
   input  logic   clk,
   input  logic   rst,
   input  regIdxT rdAddrA,
   input  regIdxT rdAddrB,
   output wordT   rdDataA,
   output wordT   rdDataB,
   wbBus.sink     wb
);

   wordT regs [8];
   logic wrEn;

   assign wrEn = wb.valid && wb.regWrite;

   always_ff @(posedge clk) begin
      if (rst) begin
         regs <= '{default: '0};
      end else if (wrEn) begin
         regs[wb.wrtReg] <= wb.wbData;
      end
   end

   // write-through so decode sees a value written in this same cycle
   assign rdDataA = (wrEn && wb.wrtReg == rdAddrA) ? wb.wbData : regs[rdAddrA];
   assign rdDataB = (wrEn && wb.wrtReg == rdAddrB) ? wb.wbData : regs[rdAddrB];

   // the write-back register is cleared by the same reset, so nothing writes here
   noWriteInReset: assert property (@(posedge clk)
      rst |=> !wrEn)
      else $error("register write while in reset");

endmodule

// File: decode.sv
// decode stage with control decode, load-use stall, forwarding select and the D/X register
`timescale 1ns/100ps

module decode import procPkg::*; (
   input  logic       clk,
   input  logic       rst,
   input  instrU      instrD,
   input  wordT       pcIncD,
   input  logic       validD,
   output regIdxT     rdAddrA,
   output regIdxT     rdAddrB,
   input  wordT       rdDataA,
   input  wordT       rdDataB,
   redirectBus.decode redirect,
   input  logic       memRegWrite,
   input  regIdxT     memWrtReg,
   input  logic       memMemRead,
   wbBus.sink         wb,
   output ctrlT       ctrlX,
   output wordT       opAX,
   output wordT       opBX,
   output wordT       immX,
   output regIdxT     destX,
   output wordT       pcIncX,
   output fwdSelT     fwdAX,
   output fwdSelT     fwdBX,
   output logic       validX
);

   ctrlT       ctrl;
   wordT       imm;
   regIdxT     dest;
   logic       useA;
   logic       useB;
   logic [7:0] imm8;
   wordT       imm5S;
   wordT       imm5Z;

   // store data lives in rd of iFmt, which is the rt position of rFmt
   assign rdAddrA = instrD.iFmt.rs;
   assign rdAddrB = instrD.rFmt.rt;
   assign imm8 = {instrD.iFmt.rd, instrD.iFmt.imm};
   assign imm5S = {{11{instrD.iFmt.imm[4]}}, instrD.iFmt.imm};
   assign imm5Z = {11'd0, instrD.iFmt.imm};

   always_comb begin
      ctrl = '0;
      imm = '0;
      dest = instrD.rFmt.rd;
      useA = 1'b0;
      useB = 1'b0;
      case (instrD.rFmt.op)
         OP_HALT: ctrl.halt = 1'b1;
         OP_NOP: begin
         end
         OP_ADDI, OP_SUBI, OP_XORI, OP_ANDNI: begin
            ctrl.useImm = 1'b1;
            ctrl.regWrite = 1'b1;
            dest = instrD.iFmt.rd;
            useA = 1'b1;
            case (instrD.iFmt.op)
               OP_ADDI: ctrl.aluOp = ALU_ADD;
               OP_SUBI: ctrl.aluOp = ALU_SUB;
               OP_XORI: ctrl.aluOp = ALU_XOR;
               default: ctrl.aluOp = ALU_ANDN;
            endcase
            // logic ops zero-extend, arithmetic ops sign-extend
            imm = (instrD.iFmt.op == OP_XORI || instrD.iFmt.op == OP_ANDNI) ? imm5Z : imm5S;
         end
         OP_LD, OP_ST: begin
            ctrl.useImm = 1'b1;
            ctrl.memRead = (instrD.iFmt.op == OP_LD);
            ctrl.memWrite = (instrD.iFmt.op == OP_ST);
            ctrl.regWrite = (instrD.iFmt.op == OP_LD);
            dest = instrD.iFmt.rd;
            imm = imm5S;
            useA = 1'b1;
            useB = (instrD.iFmt.op == OP_ST);
         end
         OP_LBI, OP_SLBI: begin
            ctrl.useImm = 1'b1;
            ctrl.regWrite = 1'b1;
            ctrl.aluOp = (instrD.iFmt.op == OP_LBI) ? ALU_PASSB : ALU_SLBI;
            dest = instrD.iFmt.rs;
            imm = (instrD.iFmt.op == OP_LBI) ? {{8{imm8[7]}}, imm8} : {8'd0, imm8};
            useA = (instrD.iFmt.op == OP_SLBI);
         end
         OP_BEQZ, OP_BNEZ: begin
            ctrl.branchKind = (instrD.iFmt.op == OP_BEQZ) ? BR_EQZ : BR_NEZ;
            imm = {{8{imm8[7]}}, imm8};
            useA = 1'b1;
         end
         OP_J, OP_JAL: begin
            ctrl.branchKind = (instrD.jFmt.op == OP_J) ? BR_JUMP : BR_JAL;
            ctrl.regWrite = (instrD.jFmt.op == OP_JAL);
            dest = 3'd7;
            imm = {{5{instrD.jFmt.disp[10]}}, instrD.jFmt.disp};
         end
         OP_ALU: begin
            ctrl.regWrite = 1'b1;
            useA = 1'b1;
            useB = 1'b1;
            case (instrD.rFmt.func)
               2'b00: ctrl.aluOp = ALU_ADD;
               2'b01: ctrl.aluOp = ALU_SUB;
               2'b10: ctrl.aluOp = ALU_XOR;
               default: ctrl.aluOp = ALU_ANDN;
            endcase
         end
         default: ctrl.illegal = 1'b1;
      endcase
   end

   // a load in execute cannot feed the next instruction in time
   assign redirect.stall = validD && validX && ctrlX.memRead &&
                           ((useA && destX == rdAddrA) || (useB && destX == rdAddrB));

   // the producer in execute moves to memory, the one in memory moves to write-back
   function automatic fwdSelT pickFwd(regIdxT src);
      if (validX && ctrlX.regWrite && destX == src) begin
         return FWD_MEM;
      end else if (memRegWrite && memWrtReg == src) begin
         return FWD_WB;
      end
      return FWD_REG;
   endfunction

   always_ff @(posedge clk) begin
      if (rst || redirect.flush || redirect.stall || !validD) begin
         validX <= 1'b0;
         ctrlX <= '0;
         fwdAX <= FWD_REG;
         fwdBX <= FWD_REG;
      end else begin
         validX <= 1'b1;
         ctrlX <= ctrl;
         fwdAX <= pickFwd(rdAddrA);
         fwdBX <= pickFwd(rdAddrB);
      end
   end

   always_ff @(posedge clk) begin
      opAX <= rdDataA;
      opBX <= rdDataB;
      immX <= imm;
      destX <= dest;
      pcIncX <= pcIncD;
   end

   noStallOnTaken: assert property (@(posedge clk) disable iff (rst)
      !(redirect.stall && redirect.taken))
      else $error("stall and taken high together");

   // the load that caused a stall is in the memory stage one cycle later
   stallLoadMoves: assert property (@(posedge clk) disable iff (rst)
      redirect.stall |=> memMemRead)
      else $error("stalled load did not reach the memory stage");

   // a write-back forward needs a producer actually writing in that stage
   wbFwdHasWriter: assert property (@(posedge clk) disable iff (rst)
      validX && (fwdAX == FWD_WB || fwdBX == FWD_WB) |-> wb.regWrite)
      else $error("write-back forward without a writer");

endmodule

// File: execute.sv
// execute stage with forwarding muxes, ALU, branch resolution and the X/M register
`timescale 1ns/100ps

module execute import procPkg::*; (
   input  logic        clk,
   input  logic        rst,
   input  ctrlT        ctrlX,
   input  wordT        opAX,
   input  wordT        opBX,
   input  wordT        immX,
   input  regIdxT      destX,
   input  wordT        pcIncX,
   input  fwdSelT      fwdAX,
   input  fwdSelT      fwdBX,
   input  logic        validX,
   redirectBus.execute redirect,
   wbBus.sink          wb,
   input  wordT        memResult,
   output ctrlT        ctrlM,
   output wordT        resultM,
   output wordT        storeDataM,
   output regIdxT      destM,
   output logic        validM,
   output logic        memRegWrite,
   output regIdxT      memWrtReg,
   output logic        memMemRead
);

   wordT opA;
   wordT opB;
   wordT aluB;
   wordT aluOut;
   wordT result;
   logic take;

   always_comb begin
      case (fwdAX)
         FWD_MEM: opA = memResult;
         FWD_WB: opA = wb.wbData;
         default: opA = opAX;
      endcase
      case (fwdBX)
         FWD_MEM: opB = memResult;
         FWD_WB: opB = wb.wbData;
         default: opB = opBX;
      endcase
   end

   assign aluB = ctrlX.useImm ? immX : opB;

   always_comb begin
      case (ctrlX.aluOp)
         ALU_SUB: aluOut = opA - aluB;
         ALU_XOR: aluOut = opA ^ aluB;
         ALU_ANDN: aluOut = opA & ~aluB;
         ALU_PASSB: aluOut = aluB;
         ALU_SLBI: aluOut = {opA[7:0], aluB[7:0]};
         default: aluOut = opA + aluB;
      endcase
   end

   // jal returns the address after itself
   assign result = (ctrlX.branchKind == BR_JAL) ? pcIncX : aluOut;

   always_comb begin
      case (ctrlX.branchKind)
         BR_EQZ: take = (opA == '0);
         BR_NEZ: take = (opA != '0);
         BR_JUMP, BR_JAL: take = 1'b1;
         default: take = 1'b0;
      endcase
   end

   // predicted not taken, so any taken control transfer redirects
   assign redirect.taken = validX && take;
   assign redirect.target = pcIncX + immX;

   always_ff @(posedge clk) begin
      if (rst || !validX) begin
         validM <= 1'b0;
         ctrlM <= '0;
      end else begin
         validM <= 1'b1;
         ctrlM <= ctrlX;
      end
   end

   always_ff @(posedge clk) begin
      resultM <= result;
      storeDataM <= opB;
      destM <= destX;
   end

   // memory-stage destination handed back to decode for forwarding
   assign memRegWrite = validM && ctrlM.regWrite;
   assign memWrtReg = destM;
   assign memMemRead = validM && ctrlM.memRead;

endmodule

// File: memory.sv
// memory stage with data memory, write-back select, the M/W register and status flags
`timescale 1ns/100ps

module memory import procPkg::*; (
   input  logic   clk,
   input  logic   rst,
   input  ctrlT   ctrlM,
   input  wordT   resultM,
   input  wordT   storeDataM,
   input  regIdxT destM,
   input  logic   validM,
   output wordT   memResult,
   wbBus.source   wb,
   output logic   halted,
   output logic   err
);

   wordT dmem [DMEM_DEPTH];
   logic [DMEM_AW-1:0] dAddr;

   assign dAddr = resultM[DMEM_AW-1:0];
   assign memResult = ctrlM.memRead ? dmem[dAddr] : resultM;

   // stores behind a halt are dropped
   always_ff @(posedge clk) begin
      if (validM && ctrlM.memWrite && !halted) begin
         dmem[dAddr] <= storeDataM;
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         wb.valid <= 1'b0;
         wb.regWrite <= 1'b0;
         halted <= 1'b0;
         err <= 1'b0;
      end else begin
         wb.valid <= validM && !halted && !ctrlM.halt;
         wb.regWrite <= validM && ctrlM.regWrite;
         halted <= halted || (validM && ctrlM.halt);
         err <= err || (validM && ctrlM.illegal && !halted);
      end
   end

   always_ff @(posedge clk) begin
      wb.wrtReg <= destM;
      wb.wbData <= memResult;
   end

   noReadAndWrite: assert property (@(posedge clk) disable iff (rst)
      !(ctrlM.memRead && ctrlM.memWrite))
      else $error("load and store decoded together");

endmodule

// File: proc.sv
// top level of the five-stage core, connects the stages and the register file
`timescale 1ns/100ps

module proc import procPkg::*; (
   input  logic               clk,
   input  logic               rst,
   input  logic               progWrEn,
   input  logic [IMEM_AW-1:0] progAddr,
   input  wordT               progData,
   output logic               halted,
   output logic               err,
   output logic               wbValid,
   output regIdxT             wbReg,
   output wordT               wbData
);

   wbBus wb();
   redirectBus redirect();

   instrU  instrD;
   wordT   pcIncD;
   logic   validD;
   regIdxT rdAddrA;
   regIdxT rdAddrB;
   wordT   rdDataA;
   wordT   rdDataB;
   ctrlT   ctrlX;
   wordT   opAX;
   wordT   opBX;
   wordT   immX;
   regIdxT destX;
   wordT   pcIncX;
   fwdSelT fwdAX;
   fwdSelT fwdBX;
   logic   validX;
   ctrlT   ctrlM;
   wordT   resultM;
   wordT   storeDataM;
   regIdxT destM;
   logic   validM;
   wordT   memResult;
   logic   memRegWrite;
   regIdxT memWrtReg;
   logic   memMemRead;

   fetch fetchInst (.clk(clk), .rst(rst), .progWrEn(progWrEn), .progAddr(progAddr),
      .progData(progData), .redirect(redirect), .halted(halted), .instrD(instrD),
      .pcIncD(pcIncD), .validD(validD));

   regFile regFileInst (.clk(clk), .rst(rst), .rdAddrA(rdAddrA), .rdAddrB(rdAddrB),
      .rdDataA(rdDataA), .rdDataB(rdDataB), .wb(wb));

   decode decodeInst (.clk(clk), .rst(rst), .instrD(instrD), .pcIncD(pcIncD),
      .validD(validD), .rdAddrA(rdAddrA), .rdAddrB(rdAddrB), .rdDataA(rdDataA),
      .rdDataB(rdDataB), .redirect(redirect), .memRegWrite(memRegWrite),
      .memWrtReg(memWrtReg), .memMemRead(memMemRead), .wb(wb), .ctrlX(ctrlX),
      .opAX(opAX), .opBX(opBX), .immX(immX), .destX(destX), .pcIncX(pcIncX),
      .fwdAX(fwdAX), .fwdBX(fwdBX), .validX(validX));

   execute executeInst (.clk(clk), .rst(rst), .ctrlX(ctrlX), .opAX(opAX), .opBX(opBX),
      .immX(immX), .destX(destX), .pcIncX(pcIncX), .fwdAX(fwdAX), .fwdBX(fwdBX),
      .validX(validX), .redirect(redirect), .wb(wb), .memResult(memResult),
      .ctrlM(ctrlM), .resultM(resultM), .storeDataM(storeDataM), .destM(destM),
      .validM(validM), .memRegWrite(memRegWrite), .memWrtReg(memWrtReg),
      .memMemRead(memMemRead));

   memory memoryInst (.clk(clk), .rst(rst), .ctrlM(ctrlM), .resultM(resultM),
      .storeDataM(storeDataM), .destM(destM), .validM(validM), .memResult(memResult),
      .wb(wb), .halted(halted), .err(err));

   // only register writes show up on the top-level write-back port
   assign wbValid = wb.valid && wb.regWrite;
   assign wbReg = wb.wrtReg;
   assign wbData = wb.wbData;

endmodule

// File: tbProc.sv
// directed testbench for the pipelined core, loads small programs and checks every register write
`timescale 1ns/100ps

module tbProc import procPkg::*; ();

   logic               clk;
   logic               rst;
   logic               progWrEn;
   logic [IMEM_AW-1:0] progAddr;
   wordT               progData;
   logic               halted;
   logic               err;
   logic               wbValid;
   regIdxT             wbReg;
   wordT               wbData;

   int          errors;
   logic [15:0] lfsrState;
   wordT        prog[$];
   regIdxT      expReg[$];
   wordT        expVal[$];
   regIdxT      gotReg[$];
   wordT        gotVal[$];
   int          gotCycle[$];

   proc proc_inst (.clk(clk), .rst(rst), .progWrEn(progWrEn), .progAddr(progAddr),
      .progData(progData), .halted(halted), .err(err), .wbValid(wbValid), .wbReg(wbReg),
      .wbData(wbData));

   initial begin
      clk = 1'b0;
      forever begin
         #10 clk = ~clk;
      end
   end

   // Galois LFSR stepped once for every bit handed out
   function automatic logic [15:0] randBits(int n);
      logic [15:0] value;
      value = '0;
      for (int i = 0; i < n; i++) begin
         value = {value[14:0], lfsrState[0]};
         lfsrState = lfsrState[0] ? ((lfsrState >> 1) ^ 16'hB400) : (lfsrState >> 1);
      end
      return value;
   endfunction

   function automatic wordT sext8(logic [7:0] v);
      return {{8{v[7]}}, v};
   endfunction

   function automatic wordT sext5(logic [4:0] v);
      return {{11{v[4]}}, v};
   endfunction

   // instruction word builders, one per encoding
   function automatic wordT aluInstr(logic [1:0] func, regIdxT rd, regIdxT rs, regIdxT rt);
      return {OP_ALU, rs, rt, rd, func};
   endfunction

   // for st the rd field names the register holding the store data
   function automatic wordT immInstr(opcodeT op, regIdxT rd, regIdxT rs, logic [4:0] imm);
      return {op, rs, rd, imm};
   endfunction

   function automatic wordT byteInstr(opcodeT op, regIdxT rs, logic [7:0] imm8);
      return {op, rs, imm8};
   endfunction

   function automatic wordT jumpInstr(opcodeT op, logic [10:0] disp);
      return {op, disp};
   endfunction

   task automatic checkValue(string what, int got, int expected);
      if (got !== expected) begin
         errors++;
         $display("error at %0t: %s is %0h, expected %0h", $time, what, got, expected);
      end
   endtask

   task automatic driveEdge();
      @(posedge clk);
      #2;
   endtask

   task automatic clearProgram();
      prog.delete();
      expReg.delete();
      expVal.delete();
   endtask

   task automatic expectWrite(regIdxT r, wordT v);
      expReg.push_back(r);
      expVal.push_back(v);
   endtask

   // writes the program through the load port, then holds reset for 5 more cycles
   task automatic loadProgram();
      int addr;
      // nops behind the program keep the slots fetched after halt harmless
      repeat (3) prog.push_back(jumpInstr(OP_NOP, 11'd0));
      driveEdge();
      rst = 1'b1;
      for (addr = 0; addr < prog.size(); addr++) begin
         driveEdge();
         progWrEn = 1'b1;
         progAddr = addr[IMEM_AW-1:0];
         progData = prog[addr];
      end
      driveEdge();
      progWrEn = 1'b0;
      repeat (5) driveEdge();
      rst = 1'b0;
   endtask

   task automatic recordWrite(int cycle);
      if (wbValid) begin
         gotReg.push_back(wbReg);
         gotVal.push_back(wbData);
         gotCycle.push_back(cycle);
      end
   endtask

   task automatic runProgram();
      int cycles;
      gotReg.delete();
      gotVal.delete();
      gotCycle.delete();
      cycles = 0;
      while (!halted && cycles < 400) begin
         @(negedge clk);
         cycles++;
         recordWrite(cycles);
      end
      if (!halted) begin
         errors++;
         $display("timeout: the core did not halt within 400 cycles");
      end
      // a few more cycles where any write would land after the halt
      repeat (6) begin
         @(negedge clk);
         cycles++;
         recordWrite(cycles);
      end
   endtask

   task automatic compareWrites(string name);
      int i;
      checkValue({name, " write count"}, gotReg.size(), expReg.size());
      for (i = 0; i < gotReg.size() && i < expReg.size(); i++) begin
         checkValue($sformatf("%s write %0d register", name, i), int'(gotReg[i]),
            int'(expReg[i]));
         checkValue($sformatf("%s write %0d value", name, i), int'(gotVal[i]),
            int'(expVal[i]));
      end
   endtask

   task automatic testAlu();
      wordT       a;
      wordT       b;
      logic [4:0] immAdd;
      logic [4:0] immSub;
      logic [4:0] immXor;
      logic [4:0] immAndn;
      int         i;
      clearProgram();
      a = randBits(16);
      b = randBits(16);
      immAdd = 5'(randBits(5));
      immSub = 5'(randBits(5));
      immXor = 5'(randBits(5));
      immAndn = 5'(randBits(5));
      prog.push_back(byteInstr(OP_LBI, 3'd1, a[15:8]));
      prog.push_back(byteInstr(OP_SLBI, 3'd1, a[7:0]));
      prog.push_back(byteInstr(OP_LBI, 3'd2, b[15:8]));
      prog.push_back(byteInstr(OP_SLBI, 3'd2, b[7:0]));
      prog.push_back(aluInstr(2'b00, 3'd3, 3'd1, 3'd2));
      prog.push_back(aluInstr(2'b01, 3'd4, 3'd1, 3'd2));
      prog.push_back(aluInstr(2'b10, 3'd5, 3'd1, 3'd2));
      prog.push_back(aluInstr(2'b11, 3'd6, 3'd1, 3'd2));
      prog.push_back(immInstr(OP_ADDI, 3'd3, 3'd1, immAdd));
      prog.push_back(immInstr(OP_SUBI, 3'd4, 3'd2, immSub));
      prog.push_back(immInstr(OP_XORI, 3'd5, 3'd1, immXor));
      prog.push_back(immInstr(OP_ANDNI, 3'd6, 3'd2, immAndn));
      prog.push_back(jumpInstr(OP_HALT, 11'd0));
      expectWrite(3'd1, sext8(a[15:8]));
      expectWrite(3'd1, a);
      expectWrite(3'd2, sext8(b[15:8]));
      expectWrite(3'd2, b);
      expectWrite(3'd3, a + b);
      expectWrite(3'd4, a - b);
      expectWrite(3'd5, a ^ b);
      expectWrite(3'd6, a & ~b);
      expectWrite(3'd3, a + sext5(immAdd));
      expectWrite(3'd4, b - sext5(immSub));
      expectWrite(3'd5, a ^ {11'd0, immXor});
      expectWrite(3'd6, b & ~{11'd0, immAndn});
      loadProgram();
      runProgram();
      compareWrites("alu");
      // no load or branch here, so one write per cycle
      for (i = 1; i < gotCycle.size(); i++) begin
         checkValue("alu write spacing", gotCycle[i] - gotCycle[i-1], 1);
      end
   endtask

   task automatic testForwarding();
      logic [7:0] x;
      wordT       s1;
      wordT       s2;
      wordT       s3;
      wordT       s4;
      clearProgram();
      x = 8'(randBits(8));
      s1 = sext8(x);
      s2 = s1 + s1;
      s3 = s2 + s2;
      s4 = s2 + s1;
      prog.push_back(byteInstr(OP_LBI, 3'd1, x));
      prog.push_back(aluInstr(2'b00, 3'd2, 3'd1, 3'd1));
      prog.push_back(aluInstr(2'b00, 3'd3, 3'd2, 3'd2));
      // r2 at distance two, r1 at distance three
      prog.push_back(aluInstr(2'b00, 3'd4, 3'd2, 3'd1));
      prog.push_back(immInstr(OP_ST, 3'd4, 3'd0, 5'd3));
      prog.push_back(immInstr(OP_LD, 3'd5, 3'd0, 5'd3));
      prog.push_back(aluInstr(2'b00, 3'd6, 3'd5, 3'd1));
      prog.push_back(immInstr(OP_ADDI, 3'd7, 3'd5, 5'd1));
      prog.push_back(jumpInstr(OP_HALT, 11'd0));
      expectWrite(3'd1, s1);
      expectWrite(3'd2, s2);
      expectWrite(3'd3, s3);
      expectWrite(3'd4, s4);
      expectWrite(3'd5, s4);
      expectWrite(3'd6, s4 + s1);
      expectWrite(3'd7, s4 + 16'd1);
      loadProgram();
      runProgram();
      compareWrites("forwarding");
   endtask

   task automatic testMemory();
      logic [7:0] x1;
      logic [7:0] x2;
      logic [7:0] x3;
      logic [7:0] x4;
      clearProgram();
      x1 = 8'(randBits(8));
      x2 = 8'(randBits(8));
      x3 = 8'(randBits(8));
      x4 = 8'(randBits(8));
      prog.push_back(byteInstr(OP_LBI, 3'd1, x1));
      prog.push_back(immInstr(OP_ST, 3'd1, 3'd0, 5'd4));
      prog.push_back(immInstr(OP_LD, 3'd2, 3'd0, 5'd4));
      prog.push_back(byteInstr(OP_LBI, 3'd3, x2));
      prog.push_back(byteInstr(OP_LBI, 3'd4, x3));
      prog.push_back(byteInstr(OP_LBI, 3'd5, x4));
      prog.push_back(immInstr(OP_ST, 3'd3, 3'd0, 5'd10));
      prog.push_back(immInstr(OP_ST, 3'd4, 3'd0, 5'd11));
      prog.push_back(immInstr(OP_ST, 3'd5, 3'd0, 5'd12));
      // read back in reverse order
      prog.push_back(immInstr(OP_LD, 3'd6, 3'd0, 5'd12));
      prog.push_back(immInstr(OP_LD, 3'd7, 3'd0, 5'd11));
      prog.push_back(immInstr(OP_LD, 3'd1, 3'd0, 5'd10));
      prog.push_back(jumpInstr(OP_HALT, 11'd0));
      expectWrite(3'd1, sext8(x1));
      expectWrite(3'd2, sext8(x1));
      expectWrite(3'd3, sext8(x2));
      expectWrite(3'd4, sext8(x3));
      expectWrite(3'd5, sext8(x4));
      expectWrite(3'd6, sext8(x4));
      expectWrite(3'd7, sext8(x3));
      expectWrite(3'd1, sext8(x2));
      loadProgram();
      runProgram();
      compareWrites("memory");
   endtask

   task automatic testControl();
      clearProgram();
      prog.push_back(byteInstr(OP_LBI, 3'd1, 8'h00));
      prog.push_back(byteInstr(OP_LBI, 3'd2, 8'h03));
      // beqz at address 2 is taken to 3 + 2
      prog.push_back(byteInstr(OP_BEQZ, 3'd1, 8'd2));
      prog.push_back(byteInstr(OP_LBI, 3'd3, 8'h11));
      prog.push_back(byteInstr(OP_LBI, 3'd3, 8'h22));
      prog.push_back(byteInstr(OP_BNEZ, 3'd1, 8'd5));
      prog.push_back(byteInstr(OP_LBI, 3'd4, 8'h44));
      // j at address 7 goes to 8 + 2
      prog.push_back(jumpInstr(OP_J, 11'd2));
      prog.push_back(byteInstr(OP_LBI, 3'd5, 8'h55));
      prog.push_back(byteInstr(OP_LBI, 3'd5, 8'h56));
      // jal at address 10 links 11 and goes to 11 + 3
      prog.push_back(jumpInstr(OP_JAL, 11'd3));
      prog.push_back(byteInstr(OP_LBI, 3'd6, 8'h61));
      prog.push_back(byteInstr(OP_LBI, 3'd6, 8'h62));
      prog.push_back(byteInstr(OP_LBI, 3'd6, 8'h63));
      prog.push_back(immInstr(OP_ADDI, 3'd6, 3'd7, 5'd1));
      prog.push_back(jumpInstr(OP_HALT, 11'd0));
      expectWrite(3'd1, 16'h0000);
      expectWrite(3'd2, 16'h0003);
      expectWrite(3'd4, 16'h0044);
      expectWrite(3'd7, 16'd11);
      expectWrite(3'd6, 16'd12);
      loadProgram();
      runProgram();
      compareWrites("control");
   endtask

   task automatic testHaltErr();
      logic [7:0] x;
      clearProgram();
      prog.push_back(byteInstr(OP_LBI, 3'd1, 8'd7));
      // opcode 11111 is not part of the instruction set
      prog.push_back(16'hF800);
      prog.push_back(immInstr(OP_ADDI, 3'd2, 3'd1, 5'd1));
      prog.push_back(jumpInstr(OP_HALT, 11'd0));
      prog.push_back(byteInstr(OP_LBI, 3'd3, 8'h33));
      prog.push_back(byteInstr(OP_LBI, 3'd4, 8'h44));
      expectWrite(3'd1, 16'd7);
      expectWrite(3'd2, 16'd8);
      loadProgram();
      runProgram();
      compareWrites("halt");
      checkValue("err after illegal opcode", int'(err), 1);
      checkValue("halted after halt", int'(halted), 1);

      // second run where err has to come back low from reset
      clearProgram();
      x = 8'(randBits(8));
      prog.push_back(byteInstr(OP_LBI, 3'd1, x));
      prog.push_back(jumpInstr(OP_HALT, 11'd0));
      expectWrite(3'd1, sext8(x));
      loadProgram();
      checkValue("err after reset", int'(err), 0);
      runProgram();
      compareWrites("rerun");
      checkValue("err on clean run", int'(err), 0);
   endtask

   initial begin
      rst = 1'b1;
      progWrEn = 1'b0;
      progAddr = '0;
      progData = '0;
      errors = 0;
      lfsrState = 16'd34695;
      testAlu();
      testForwarding();
      testMemory();
      testControl();
      testHaltErr();
      $display("checks done with %0d errors", errors);
      if (errors == 0) begin
         $display("test passed");
      end else begin
         $display("test failed");
      end
      $finish;
   end

endmodule

// File: sources.f
procPkg.sv
pipeIf.sv
fetch.sv
regFile.sv
decode.sv
execute.sv
memory.sv
proc.sv
tbProc.sv

// File: run.sh
#!/bin/sh
# build the core and its testbench with Verilator, run it and look for the pass line
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tbProc -f sources.f -o simProc

./obj_dir/simProc | tee sim.log

grep -qx "test passed" sim.log
